//--- Bender.yml
package:
  name: ruche_row

sources:
  - rtl/ruche_cfg_pkg.sv
  - rtl/ruche_pkt_pkg.sv
  - rtl/ruche_link_if.sv
  - rtl/ruche_inject_decode.sv
  - rtl/ruche_router.sv
  - rtl/ruche_tile_exec.sv
  - rtl/ruche_result.sv
  - rtl/ruche_row_top.sv
  - target: simulation
    files:
      - sim/ruche_row_tb.sv

//--- rtl/ruche_cfg_pkg.sv
/*
 * Geometry of the tile row and sizing of each tile's data memory.
 * Imported by the packet package and by every RTL module of the row.
 */

package ruche_cfg_pkg;

  // row geometry
  localparam int num_tiles_x  = 6;
  localparam int ruche_factor = 3;
  localparam int x_cord_width = 3;

  // remaining and used hop counts share one width, max remaining is 6
  localparam int hop_width    = 3;

  // per-tile data memory
  localparam int mem_words    = 8;
  localparam int addr_width   = 3;
  localparam int data_width   = 16;

endpackage

//--- rtl/ruche_inject_decode.sv
/*
 * West-edge injector. Takes one request per handshake, rejects a
 * destination outside the row and launches a legal one on the ruche or
 * local link in the cycle after acceptance.
 */

`timescale 1ns/1ps

module ruche_inject_decode (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 in_valid_i,
  input  logic                                 in_ready_i,
  input  logic [ruche_cfg_pkg::x_cord_width-1:0] in_dest_i,
  input  ruche_pkt_pkg::op_e                   in_op_i,
  input  logic [ruche_cfg_pkg::addr_width-1:0] in_addr_i,
  input  logic [ruche_cfg_pkg::data_width-1:0] in_data_i,
  ruche_link_if.tx                             local_o,
  ruche_link_if.tx                             ruche_o,
  output logic                                 reject_o
);

  import ruche_cfg_pkg::*;
  import ruche_pkt_pkg::*;

  logic                 accept;
  logic                 legal;
  logic                 to_ruche;
  logic [hop_width-1:0] first_rem;
  ruche_pkt_s           pkt_d;
  ruche_pkt_s           pkt_q;
  logic                 local_q;
  logic                 ruche_q;
  logic                 reject_q;

  assign accept = in_valid_i & in_ready_i;
  assign legal  = in_dest_i < x_cord_width'(num_tiles_x);

  // tile d sits d+1 tile steps from the west edge
  assign first_rem = hop_width'(in_dest_i) + 1'b1;
  assign to_ruche  = first_rem >= hop_width'(ruche_factor);

  always_comb begin
    pkt_d.dest_x = in_dest_i;
    pkt_d.rem    = first_rem;
    pkt_d.hops   = '0;
    pkt_d.op     = in_op_i;
    pkt_d.addr   = in_addr_i;
    pkt_d.data   = in_data_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      local_q  <= 1'b0;
      ruche_q  <= 1'b0;
      reject_q <= 1'b0;
    end else begin
      local_q  <= accept & legal & ~to_ruche;
      ruche_q  <= accept & legal & to_ruche;
      reject_q <= accept & ~legal;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && legal) begin
      pkt_q <= pkt_d;
    end
  end

  assign local_o.valid = local_q;
  assign local_o.pkt   = pkt_q;
  assign ruche_o.valid = ruche_q;
  assign ruche_o.pkt   = pkt_q;
  assign reject_o      = reject_q;

endmodule

//--- rtl/ruche_link_if.sv
/*
 * One eastbound link hop, local or ruche.
 * The sender drives valid and pkt from registers, the receiver samples them.
 * valid is a single-cycle strobe with no ready in the other direction.
 */

`timescale 1ns/1ps

interface ruche_link_if;

  import ruche_pkt_pkg::*;

  logic       valid;
  ruche_pkt_s pkt;

  // sending router or injector
  modport tx (
    output valid,
    output pkt
  );

  // receiving router
  modport rx (
    input valid,
    input pkt
  );

endinterface

//--- rtl/ruche_pkt_pkg.sv
/*
 * Packet formats for the ruche row: opcodes, response status,
 * the packet carried on every link hop and the response to the host.
 */

package ruche_pkt_pkg;

  import ruche_cfg_pkg::*;

  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_add   = 2'd2
  } op_e;

  typedef enum logic {
    status_ok       = 1'b0,
    status_bad_dest = 1'b1
  } status_e;

  // rem counts tile steps still to go, hops counts links taken
  typedef struct packed {
    logic [x_cord_width-1:0] dest_x;
    logic [hop_width-1:0]    rem;
    logic [hop_width-1:0]    hops;
    op_e                     op;
    logic [addr_width-1:0]   addr;
    logic [data_width-1:0]   data;
  } ruche_pkt_s;

  typedef struct packed {
    status_e                 status;
    op_e                     op;
    logic [x_cord_width-1:0] tile_x;
    logic [data_width-1:0]   data;
    logic [hop_width-1:0]    hops;
  } ruche_resp_s;

endpackage

//--- rtl/ruche_result.sv
/*
 * Response collector. Picks the one tile that finished, or turns a
 * reject into a bad_dest response, and registers it onto the outputs.
 * Also owns the input ready level for the whole row.
 */

`timescale 1ns/1ps

module ruche_result (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   accept_i,
  input  logic                                   reject_i,
  input  logic [ruche_cfg_pkg::num_tiles_x-1:0]  done_i,
  input  ruche_pkt_pkg::ruche_resp_s [ruche_cfg_pkg::num_tiles_x-1:0] resp_i,
  output logic                                   ready_o,
  output logic                                   resp_valid_o,
  output ruche_pkt_pkg::ruche_resp_s             resp_o
);

  import ruche_cfg_pkg::*;
  import ruche_pkt_pkg::*;

  logic        tile_hit;
  logic        issue;
  logic        reject_q;
  logic        ready_q;
  logic        resp_valid_q;
  ruche_resp_s tile_resp;
  ruche_resp_s bad_resp;
  ruche_resp_s resp_q;

  // only one tile can report done for the single request in flight
  always_comb begin
    tile_hit  = 1'b0;
    tile_resp = '0;
    for (int i = 0; i < num_tiles_x; i++) begin
      if (done_i[i]) begin
        tile_hit  = 1'b1;
        tile_resp = resp_i[i];
      end
    end
  end

  always_comb begin
    bad_resp        = '0;
    bad_resp.status = status_bad_dest;
    bad_resp.op     = op_read;
  end

  assign issue = tile_hit | reject_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reject_q     <= 1'b0;
      ready_q      <= 1'b1;
      resp_valid_q <= 1'b0;
    end else begin
      // reject spends one stage here, in step with the execute cycle
      reject_q     <= reject_i;
      resp_valid_q <= issue;
      if (accept_i) begin
        ready_q <= 1'b0;
      end else if (issue) begin
        ready_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      resp_q <= tile_hit ? tile_resp : bad_resp;
    end
  end

  assign ready_o      = ready_q;
  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

//--- rtl/ruche_router.sv
/*
 * Per-tile router, one register stage per hop. Accounts for the link the
 * packet came in on, then ejects it to the tile, keeps it on the ruche
 * network or turns it onto the local network.
 */

`timescale 1ns/1ps

module ruche_router (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  ruche_link_if.rx                 local_i,
  ruche_link_if.rx                 ruche_i,
  ruche_link_if.tx                 local_o,
  ruche_link_if.tx                 ruche_o,
  output logic                     eject_valid_o,
  output ruche_pkt_pkg::ruche_pkt_s eject_pkt_o
);

  import ruche_cfg_pkg::*;
  import ruche_pkt_pkg::*;

  logic       arrive;
  logic       via_ruche;
  logic       eject_d;
  logic       ruche_d;
  logic       local_d;
  ruche_pkt_s pkt_in;
  ruche_pkt_s pkt_nxt;
  ruche_pkt_s pkt_q;
  logic       eject_q;
  logic       ruche_q;
  logic       local_q;

  // one packet in flight, so at most one input is valid
  assign via_ruche = ruche_i.valid;
  assign arrive    = local_i.valid | ruche_i.valid;

  always_comb begin
    pkt_in       = via_ruche ? ruche_i.pkt : local_i.pkt;
    pkt_nxt      = pkt_in;
    pkt_nxt.hops = pkt_in.hops + 1'b1;
    // a ruche link covers ruche_factor tiles
    if (via_ruche) begin
      pkt_nxt.rem = pkt_in.rem - hop_width'(ruche_factor);
    end else begin
      pkt_nxt.rem = pkt_in.rem - 1'b1;
    end
  end

  // routing decision
  assign eject_d = arrive & (pkt_nxt.rem == '0);
  assign ruche_d = arrive & via_ruche & (pkt_nxt.rem >= hop_width'(ruche_factor));
  assign local_d = arrive & ~eject_d & ~ruche_d;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eject_q <= 1'b0;
      ruche_q <= 1'b0;
      local_q <= 1'b0;
    end else begin
      eject_q <= eject_d;
      ruche_q <= ruche_d;
      local_q <= local_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (arrive) begin
      pkt_q <= pkt_nxt;
    end
  end

  assign local_o.valid = local_q;
  assign local_o.pkt   = pkt_q;
  assign ruche_o.valid = ruche_q;
  assign ruche_o.pkt   = pkt_q;
  assign eject_valid_o = eject_q;
  assign eject_pkt_o   = pkt_q;

endmodule

//--- rtl/ruche_row_top.sv
/*
 * Top of the ruche row: injector, six router and execute pairs and the
 * collector, joined by local links (one tile per hop) and ruche links
 * (three tiles per hop). Ports are plain signals for the host.
 */

`timescale 1ns/1ps

module ruche_row_top (
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,
  input  logic                                   in_valid_i,
  input  logic [ruche_cfg_pkg::x_cord_width-1:0] in_dest_i,
  input  ruche_pkt_pkg::op_e                     in_op_i,
  input  logic [ruche_cfg_pkg::addr_width-1:0]   in_addr_i,
  input  logic [ruche_cfg_pkg::data_width-1:0]   in_data_i,
  output logic                                   in_ready_o,
  output logic                                   resp_valid_o,
  output ruche_pkt_pkg::status_e                 resp_status_o,
  output ruche_pkt_pkg::op_e                     resp_op_o,
  output logic [ruche_cfg_pkg::x_cord_width-1:0] resp_x_o,
  output logic [ruche_cfg_pkg::data_width-1:0]   resp_data_o,
  output logic [ruche_cfg_pkg::hop_width-1:0]    resp_hops_o
);

  import ruche_cfg_pkg::*;
  import ruche_pkt_pkg::*;

  logic                                  accept;
  logic                                  ready;
  logic                                  reject;
  logic        [num_tiles_x-1:0]         eject_valid;
  ruche_pkt_s  [num_tiles_x-1:0]         eject_pkt;
  logic        [num_tiles_x-1:0]         done;
  ruche_resp_s [num_tiles_x-1:0]         tile_resp;
  ruche_resp_s                           resp;

  // local_link[x] feeds router x, router x drives local_link[x+1]
  ruche_link_if local_link [num_tiles_x+1] ();
  // ruche_link[x] feeds router x, router x drives ruche_link[x+ruche_factor]
  ruche_link_if ruche_link [num_tiles_x+ruche_factor] ();

  assign accept = in_valid_i & ready;

  ruche_inject_decode u_decode (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .in_valid_i (in_valid_i),
    .in_ready_i (ready),
    .in_dest_i  (in_dest_i),
    .in_op_i    (in_op_i),
    .in_addr_i  (in_addr_i),
    .in_data_i  (in_data_i),
    .local_o    (local_link[0]),
    .ruche_o    (ruche_link[ruche_factor-1]),
    .reject_o   (reject)
  );

  for (genvar x = 0; x < num_tiles_x; x++) begin : g_tile
    ruche_router u_router (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .local_i       (local_link[x]),
      .ruche_i       (ruche_link[x]),
      .local_o       (local_link[x+1]),
      .ruche_o       (ruche_link[x+ruche_factor]),
      .eject_valid_o (eject_valid[x]),
      .eject_pkt_o   (eject_pkt[x])
    );

    ruche_tile_exec #(
      .tile_x (x)
    ) u_exec (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_valid_i (eject_valid[x]),
      .req_pkt_i   (eject_pkt[x]),
      .done_o      (done[x]),
      .resp_o      (tile_resp[x])
    );
  end

  // west ruche inputs of tiles 0 and 1 have no source
  for (genvar t = 0; t < ruche_factor-1; t++) begin : g_ruche_tie
    assign ruche_link[t].valid = 1'b0;
    assign ruche_link[t].pkt   = '0;
  end

  ruche_result u_result (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .accept_i     (accept),
    .reject_i     (reject),
    .done_i       (done),
    .resp_i       (tile_resp),
    .ready_o      (ready),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp)
  );

  assign in_ready_o    = ready;
  assign resp_status_o = resp.status;
  assign resp_op_o     = resp.op;
  assign resp_x_o      = resp.tile_x;
  assign resp_data_o   = resp.data;
  assign resp_hops_o   = resp.hops;

endmodule

//--- rtl/ruche_tile_exec.sv
/*
 * Execute unit of one tile. Holds the tile's data memory and runs
 * read, write or add on an ejected packet in a single cycle.
 * tile_x is the tile's own column index, returned in the response.
 */

`timescale 1ns/1ps

module ruche_tile_exec #(
  parameter int tile_x = 0
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      req_valid_i,
  input  ruche_pkt_pkg::ruche_pkt_s req_pkt_i,
  output logic                      done_o,
  output ruche_pkt_pkg::ruche_resp_s resp_o
);

  import ruche_cfg_pkg::*;
  import ruche_pkt_pkg::*;

  logic [data_width-1:0] mem_q [mem_words];
  logic [data_width-1:0] old_word;
  logic [data_width-1:0] sum_word;
  logic                  done_q;
  ruche_resp_s           resp_q;

  assign old_word = mem_q[req_pkt_i.addr];
  // wraps modulo 2^16
  assign sum_word = old_word + req_pkt_i.data;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < mem_words; i++) begin
        mem_q[i] <= '0;
      end
      done_q <= 1'b0;
    end else begin
      done_q <= req_valid_i;
      if (req_valid_i) begin
        case (req_pkt_i.op)
          op_write: mem_q[req_pkt_i.addr] <= req_pkt_i.data;
          op_add:   mem_q[req_pkt_i.addr] <= sum_word;
          default:  ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      resp_q.status <= status_ok;
      resp_q.op     <= req_pkt_i.op;
      resp_q.tile_x <= x_cord_width'(tile_x);
      // write hands back the old word, add the new one
      resp_q.data   <= (req_pkt_i.op == op_add) ? sum_word : old_word;
      resp_q.hops   <= req_pkt_i.hops;
    end
  end

  assign done_o = done_q;
  assign resp_o = resp_q;

endmodule

//--- sim.f
rtl/ruche_cfg_pkg.sv
rtl/ruche_pkt_pkg.sv
rtl/ruche_link_if.sv
rtl/ruche_inject_decode.sv
rtl/ruche_router.sv
rtl/ruche_tile_exec.sv
rtl/ruche_result.sv
rtl/ruche_row_top.sv
sim/ruche_row_tb.sv

//--- sim/ruche_row_golden.txt
// columns: dest op addr data exp_status exp_data exp_hops, all hex
// op 0 read 1 write 2 add, status 0 ok 1 bad_dest, dest ff ends the list
0 1 3 1234 0 0000 1
0 0 3 0000 0 1234 1
3 0 3 0000 0 0000 2
3 1 3 abcd 0 0000 2
0 1 3 5555 0 1234 1
3 0 3 0000 0 abcd 2
5 2 0 0010 0 0010 2
5 2 0 0005 0 0015 2
4 1 6 fff0 0 0000 3
4 2 6 0020 0 0010 3
4 0 6 0000 0 0010 3
1 1 7 ffff 0 0000 2
1 2 7 ffff 0 fffe 2
6 1 0 9999 1 0000 0
7 2 6 1111 1 0000 0
4 0 6 0000 0 0010 3
2 1 2 0042 0 0000 1
2 0 2 0000 0 0042 1
ff 0 0 0000 0 0000 0

//--- sim/ruche_row_tb.sv
/*
 * Testbench for the ruche row. Replays the golden request file, sweeps
 * every tile and address with reads, then issues seeded random requests
 * checked against a reference memory model kept in the testbench.
 */

`timescale 1ns/1ps

module ruche_row_tb;

  import ruche_cfg_pkg::*;
  import ruche_pkt_pkg::*;

  localparam int fields      = 7;
  localparam int max_entries = 32;
  localparam int wait_limit  = 50;

  logic                    clk_i;
  logic                    arst_n_i;
  logic                    in_valid_i;
  logic [x_cord_width-1:0] in_dest_i;
  op_e                     in_op_i;
  logic [addr_width-1:0]   in_addr_i;
  logic [data_width-1:0]   in_data_i;
  logic                    in_ready_o;
  logic                    resp_valid_o;
  status_e                 resp_status_o;
  op_e                     resp_op_o;
  logic [x_cord_width-1:0] resp_x_o;
  logic [data_width-1:0]   resp_data_o;
  logic [hop_width-1:0]    resp_hops_o;

  logic [15:0]           golden [max_entries*fields];
  logic [data_width-1:0] ref_mem [num_tiles_x][mem_words];
  int                    errors;
  int                    timeouts;

  ruche_row_top dut_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .in_valid_i    (in_valid_i),
    .in_dest_i     (in_dest_i),
    .in_op_i       (in_op_i),
    .in_addr_i     (in_addr_i),
    .in_data_i     (in_data_i),
    .in_ready_o    (in_ready_o),
    .resp_valid_o  (resp_valid_o),
    .resp_status_o (resp_status_o),
    .resp_op_o     (resp_op_o),
    .resp_x_o      (resp_x_o),
    .resp_data_o   (resp_data_o),
    .resp_hops_o   (resp_hops_o)
  );

  always #4 clk_i = ~clk_i;

  // ruche hops first, local hops for the rest
  function automatic int expected_hops(input int d);
    return (d + 1) / 3 + (d + 1) % 3;
  endfunction

  task automatic compare_code(input status_e exp_status, input status_e act_status,
                              input op_e exp_op, input op_e act_op, input bit with_op);
    if (act_status !== exp_status) begin
      errors++;
      $display("error at %0t: resp_status_o expected %s got %s", $time,
               exp_status.name(), act_status.name());
    end
    if (with_op && act_op !== exp_op) begin
      errors++;
      $display("error at %0t: resp_op_o expected %s got %s", $time,
               exp_op.name(), act_op.name());
    end
  endtask

  task automatic compare_field(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
    if (act !== exp) begin
      errors++;
      $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // reference model of the tile memories
  task automatic model_apply(input int d, input op_e op, input int a,
                             input logic [data_width-1:0] data, output status_e st,
                             output logic [data_width-1:0] rd, output logic [hop_width-1:0] hops);
    logic [data_width-1:0] old;
    if (d >= num_tiles_x) begin
      st   = status_bad_dest;
      rd   = '0;
      hops = '0;
    end else begin
      old  = ref_mem[d][a];
      st   = status_ok;
      hops = hop_width'(expected_hops(d));
      rd   = old;
      if (op == op_write) begin
        ref_mem[d][a] = data;
      end else if (op == op_add) begin
        rd            = old + data;
        ref_mem[d][a] = rd;
      end
    end
  endtask

  task automatic run_request(input logic [x_cord_width-1:0] dest, input op_e op,
                             input logic [addr_width-1:0] addr, input logic [data_width-1:0] data,
                             input status_e exp_st, input logic [data_width-1:0] exp_data,
                             input logic [hop_width-1:0] exp_hops);
    int t;
    int lat;
    int exp_lat;
    @(negedge clk_i);
    t = 0;
    while (!in_ready_o && t < wait_limit) begin
      @(negedge clk_i);
      t++;
    end
    if (!in_ready_o) begin
      timeouts++;
      $display("timeout at %0t: in_ready_o never went high", $time);
      return;
    end
    if (resp_valid_o) begin
      errors++;
      $display("unexpected response at %0t with no request in flight", $time);
    end
    in_valid_i = 1'b1;
    in_dest_i  = dest;
    in_op_i    = op;
    in_addr_i  = addr;
    in_data_i  = data;
    @(posedge clk_i);
    @(negedge clk_i);
    // offered while busy and never taken
    in_dest_i = '0;
    in_op_i   = op_write;
    in_addr_i = addr_width'(7);
    in_data_i = 16'hbeef;
    lat = 0;
    while (!resp_valid_o && lat < wait_limit) begin
      if (in_ready_o) begin
        errors++;
        $display("in_ready_o high at %0t while a request is in flight", $time);
      end
      @(negedge clk_i);
      lat++;
    end
    in_valid_i = 1'b0;
    if (!resp_valid_o) begin
      timeouts++;
      $display("timeout at %0t: no response for dest %0d", $time, dest);
      return;
    end
    if (!in_ready_o) begin
      errors++;
      $display("in_ready_o still low at %0t when the response was issued", $time);
    end
    compare_code(exp_st, resp_status_o, op, resp_op_o, exp_st == status_ok);
    exp_lat = (exp_st == status_ok) ? int'(exp_hops) + 2 : 2;
    compare_field("latency", 16'(exp_lat), 16'(lat));
    if (exp_st == status_ok) begin
      compare_field("resp_data_o", exp_data, resp_data_o);
      compare_field("resp_x_o", 16'(dest), 16'(resp_x_o));
      compare_field("resp_hops_o", 16'(exp_hops), 16'(resp_hops_o));
    end
  endtask

  task automatic read_sweep();
    status_e               st;
    logic [data_width-1:0] rd;
    logic [hop_width-1:0]  hops;
    for (int d = 0; d < num_tiles_x; d++) begin
      for (int a = 0; a < mem_words; a++) begin
        model_apply(d, op_read, a, '0, st, rd, hops);
        run_request(x_cord_width'(d), op_read, addr_width'(a), '0, st, rd, hops);
      end
    end
  endtask

  initial begin
    integer                seed;
    integer                rnd;
    int                    e;
    int                    b;
    status_e               st;
    logic [data_width-1:0] rd;
    logic [hop_width-1:0]  hops;
    op_e                   r_op;
    seed       = 89;
    errors     = 0;
    timeouts   = 0;
    clk_i      = 1'b0;
    arst_n_i   = 1'b0;
    in_valid_i = 1'b0;
    in_dest_i  = '0;
    in_op_i    = op_read;
    in_addr_i  = '0;
    in_data_i  = '0;
    for (int d = 0; d < num_tiles_x; d++) begin
      for (int a = 0; a < mem_words; a++) begin
        ref_mem[d][a] = '0;
      end
    end
    $readmemh("sim/ruche_row_golden.txt", golden);
    if ($isunknown(golden[0])) begin
      errors++;
      $display("golden file could not be read");
    end

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    if (!in_ready_o || resp_valid_o) begin
      errors++;
      $display("after reset in_ready_o is not high or resp_valid_o is not low");
    end

    // every tile and address reads zero
    read_sweep();

    // directed requests up to the end marker with dest ff
    e = 0;
    while (e < max_entries && !$isunknown(golden[e*fields]) && golden[e*fields] != 16'hff) begin
      b = e * fields;
      model_apply(int'(golden[b]), op_e'(golden[b+1][1:0]), int'(golden[b+2][2:0]),
                  golden[b+3], st, rd, hops);
      if (st !== status_e'(golden[b+4][0]) || rd !== golden[b+5] ||
          hops !== golden[b+6][hop_width-1:0]) begin
        errors++;
        $display("golden entry %0d disagrees with the reference model", e);
      end
      run_request(golden[b][x_cord_width-1:0], op_e'(golden[b+1][1:0]),
                  golden[b+2][addr_width-1:0], golden[b+3], status_e'(golden[b+4][0]),
                  golden[b+5], golden[b+6][hop_width-1:0]);
      e++;
    end

    // seeded random requests
    for (int i = 0; i < 20; i++) begin
      rnd  = $random(seed);
      r_op = op_e'((rnd & 32'hff) % 3);
      model_apply(rnd[10:8], r_op, rnd[14:12], rnd[31:16], st, rd, hops);
      run_request(rnd[10:8], r_op, rnd[14:12], rnd[31:16], st, rd, hops);
    end

    // bad dests and ignored requests left memories untouched
    read_sweep();

    repeat (10) begin
      @(negedge clk_i);
      if (resp_valid_o) begin
        errors++;
        $display("stray response at %0t after the last request", $time);
      end
    end

    $display("errors: %0d timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
